/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing -j 0
LINTFLAGS = --lint-only --timing
TOP       = cpuTb
FILELIST  = files.f
OBJDIR    = obj_dir
PASSTEXT  = '** PASS **'

.PHONY: all lint clean

all:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP) | tee /dev/stderr | grep -F $(PASSTEXT) > /dev/null

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR)

/* common/cpuCtrlPkg.sv */
`default_nettype none

package cpuCtrlPkg;

	typedef enum logic [2:0] {
		stIdle,
		stFetch,
		stDecode,
		stExecute,
		stWriteback,
		stHalted
	} seqStateT;

	// writeback source
	typedef logic [1:0] wbSelT;
	localparam wbSelT wbAlu  = 2'b10;
	localparam wbSelT wbMem  = 2'b01;
	localparam wbSelT wbLink = 2'b00; // pc + 1

	// alu operand b source
	typedef logic bSelT;
	localparam bSelT bSelReg = 1'b0;
	localparam bSelT bSelImm = 1'b1;

endpackage

`default_nettype wire

/* common/cpuIsaPkg.sv */
`default_nettype none

package cpuIsaPkg;

	typedef logic [15:0] wordT;
	typedef logic [31:0] instrT;
	typedef logic [15:0] immT;
	typedef logic [2:0]  regAddrT;
	typedef logic [7:0]  imemAddrT;
	typedef logic [7:0]  dmemAddrT; // low byte of computed address
	typedef logic [4:0]  aluOpT;
	typedef logic [2:0]  flagTestT;

	typedef enum logic [2:0] {
		typeBranch = 3'b000,
		typeAluReg = 3'b001,
		typeAluImm = 3'b010,
		typeMem    = 3'b100, // op[4] set for store
		typeJump   = 3'b110,
		typeHalt   = 3'b111
	} instrTypeT;

	// other codes give zero
	localparam aluOpT aluAdd   = 5'b00000;
	localparam aluOpT aluSub   = 5'b00001;
	localparam aluOpT aluAnd   = 5'b01000;
	localparam aluOpT aluOr    = 5'b01001;
	localparam aluOpT aluXor   = 5'b01010;
	localparam aluOpT aluShl   = 5'b10000;
	localparam aluOpT aluShr   = 5'b10001;
	localparam aluOpT aluPassB = 5'b10011;

	localparam flagTestT testNever   = 3'b000;
	localparam flagTestT testZero    = 3'b001;
	localparam flagTestT testNonZero = 3'b010;
	localparam flagTestT testAlways  = 3'b011;
	localparam flagTestT testNeg     = 3'b100;
	localparam flagTestT testNonNeg  = 3'b101;
	localparam flagTestT testCarry   = 3'b110;
	localparam flagTestT testNoCarry = 3'b111;

	// ####################
	// field extraction

	function automatic instrTypeT typeOf(instrT instr);
		return instrTypeT'(instr[31:29]);
	endfunction

	function automatic aluOpT opOf(instrT instr);
		return instr[28:24];
	endfunction

	function automatic regAddrT rdOf(instrT instr);
		return instr[23:21];
	endfunction

	function automatic regAddrT rsOf(instrT instr);
		return instr[20:18];
	endfunction

	function automatic regAddrT rtOf(instrT instr);
		return instr[2:0]; // overlaps imm
	endfunction

	function automatic immT immOf(instrT instr);
		return instr[15:0];
	endfunction

endpackage

`default_nettype wire

/* common/cpu_macros.svh */
`ifndef CPU_MACROS_SVH
`define CPU_MACROS_SVH

// ####################
// sizes
// ####################

`define CPU_IMEM_DEPTH 256 // instruction words
`define CPU_DMEM_DEPTH 256 // data words
`define CPU_REG_COUNT  8

// cycles allowed past four per instruction before a run counts as hung
`define CPU_HALT_MARGIN 64

`endif

/* control/controlUnit.sv */
`timescale 1ns/1ps
`default_nettype none

module controlUnit (
	input  wire                       CLK,
	input  wire                       arstN,
	input  wire                       run,
	input  wire cpuIsaPkg::instrTypeT instrType,
	input  wire cpuIsaPkg::aluOpT     op,
	output cpuIsaPkg::aluOpT          aluOp,
	output cpuIsaPkg::flagTestT       flagTest,
	output logic                      signExt,
	output cpuCtrlPkg::bSelT          bSel,
	output logic                      dmWe,
	output logic                      rfWe,
	output cpuCtrlPkg::wbSelT         wbSel,
	output logic                      irWe,
	output logic                      pcWe,
	output logic                      pcBranchSel,
	output logic                      halted,
	output logic                      idle
);
	cpuCtrlPkg::seqStateT state, nextState;

	cpuIsaPkg::aluOpT    decAluOp;
	cpuIsaPkg::flagTestT decFlagTest;
	cpuCtrlPkg::bSelT    decBSel;
	cpuCtrlPkg::wbSelT   decWbSel;
	logic decSignExt, decStore, decRfWe, decBranch;
	logic rfWeHold; // decoded register write, released in writeback

	// ####################
	// sequencer

	always_comb begin
		nextState = state;
		case (state)
			cpuCtrlPkg::stIdle:      if (run) nextState = cpuCtrlPkg::stFetch;
			cpuCtrlPkg::stFetch:     nextState = cpuCtrlPkg::stDecode;
			cpuCtrlPkg::stDecode:    nextState = (instrType == cpuIsaPkg::typeHalt) ?
				cpuCtrlPkg::stHalted : cpuCtrlPkg::stExecute;
			cpuCtrlPkg::stExecute:   nextState = cpuCtrlPkg::stWriteback;
			cpuCtrlPkg::stWriteback: nextState = cpuCtrlPkg::stFetch;
			cpuCtrlPkg::stHalted:    nextState = cpuCtrlPkg::stHalted; // until reset
			default:                 nextState = cpuCtrlPkg::stIdle;
		endcase
	end

	assign idle   = (state == cpuCtrlPkg::stIdle);
	assign halted = (state == cpuCtrlPkg::stHalted);

	// ####################
	// decoder

	always_comb begin
		decAluOp    = cpuIsaPkg::aluAdd;
		decFlagTest = cpuIsaPkg::testNever;
		decSignExt  = 1'b0;
		decBSel     = cpuCtrlPkg::bSelReg;
		decStore    = 1'b0;
		decRfWe     = 1'b0;
		decWbSel    = cpuCtrlPkg::wbAlu;
		decBranch   = 1'b0;
		case (instrType)
			cpuIsaPkg::typeAluReg: begin
				decAluOp = op;
				decRfWe  = 1'b1;
			end
			cpuIsaPkg::typeAluImm: begin
				decAluOp   = op;
				decSignExt = 1'b1;
				decBSel    = cpuCtrlPkg::bSelImm;
				decRfWe    = 1'b1;
			end
			cpuIsaPkg::typeMem: begin
				decSignExt = 1'b1; // rs + imm
				decBSel    = cpuCtrlPkg::bSelImm;
				decStore   = op[4];
				decRfWe    = ~op[4];
				decWbSel   = cpuCtrlPkg::wbMem;
			end
			cpuIsaPkg::typeBranch: begin
				decAluOp    = cpuIsaPkg::aluPassB; // target through alu
				decFlagTest = op[4:2];
				decBSel     = cpuCtrlPkg::bSelImm;
				decBranch   = 1'b1;
			end
			cpuIsaPkg::typeJump: begin
				decAluOp    = cpuIsaPkg::aluPassB;
				decFlagTest = cpuIsaPkg::testAlways;
				decBSel     = cpuCtrlPkg::bSelImm;
				decBranch   = 1'b1;
				decRfWe     = 1'b1;
				decWbSel    = cpuCtrlPkg::wbLink;
			end
			default: ; // halt
		endcase
	end

	always_ff @(posedge CLK or negedge arstN) begin
		if (!arstN) begin
			state       <= cpuCtrlPkg::stIdle;
			aluOp       <= '0;
			flagTest    <= cpuIsaPkg::testNever;
			signExt     <= 1'b0;
			bSel        <= cpuCtrlPkg::bSelReg;
			wbSel       <= cpuCtrlPkg::wbLink;
			pcBranchSel <= 1'b0;
			rfWeHold    <= 1'b0;
			irWe        <= 1'b0;
			dmWe        <= 1'b0;
			rfWe        <= 1'b0;
			pcWe        <= 1'b0;
		end else begin
			state <= nextState;
			if (state == cpuCtrlPkg::stDecode) begin
				aluOp       <= decAluOp;
				flagTest    <= decFlagTest;
				signExt     <= decSignExt;
				bSel        <= decBSel;
				wbSel       <= decWbSel;
				pcBranchSel <= decBranch;
				rfWeHold    <= decRfWe;
			end
			irWe <= (nextState == cpuCtrlPkg::stFetch);
			dmWe <= (state == cpuCtrlPkg::stDecode) && decStore; // high in execute
			rfWe <= (state == cpuCtrlPkg::stExecute) && rfWeHold; // high in writeback
			pcWe <= (state == cpuCtrlPkg::stExecute);
		end
	end

endmodule

`default_nettype wire

/* datapath/alu.sv */
`timescale 1ns/1ps
`default_nettype none

module alu (
	input  wire                   CLK,
	input  wire                   arstN,
	input  wire cpuIsaPkg::aluOpT aluOp,
	input  wire cpuIsaPkg::wordT  a,
	input  wire cpuIsaPkg::wordT  b,
	output cpuIsaPkg::wordT       result,
	output logic                  zero,
	output logic                  negative,
	output logic                  carry
);
	cpuIsaPkg::wordT nextResult;
	logic nextCarry;

	always_comb begin
		nextCarry  = 1'b0;
		nextResult = '0;
		case (aluOp)
			cpuIsaPkg::aluAdd:   {nextCarry, nextResult} = {1'b0, a} + {1'b0, b};
			cpuIsaPkg::aluSub:   {nextCarry, nextResult} = {1'b0, a} - {1'b0, b}; // borrow
			cpuIsaPkg::aluAnd:   nextResult = a & b;
			cpuIsaPkg::aluOr:    nextResult = a | b;
			cpuIsaPkg::aluXor:   nextResult = a ^ b;
			cpuIsaPkg::aluShl:   nextResult = a << b[3:0];
			cpuIsaPkg::aluShr:   nextResult = a >> b[3:0]; // logical
			cpuIsaPkg::aluPassB: nextResult = b;
			default:             nextResult = '0;
		endcase
	end

	always_ff @(posedge CLK or negedge arstN) begin
		if (!arstN) begin
			result   <= '0;
			zero     <= 1'b0;
			negative <= 1'b0;
			carry    <= 1'b0;
		end else begin
			result   <= nextResult;
			zero     <= (nextResult == '0);
			negative <= nextResult[$bits(nextResult)-1];
			carry    <= nextCarry;
		end
	end

endmodule

`default_nettype wire

/* datapath/flagUnit.sv */
`timescale 1ns/1ps
`default_nettype none

module flagUnit (
	input  wire                      CLK,
	input  wire                      arstN,
	input  wire                      flagLoad,
	input  wire                      zero,
	input  wire                      negative,
	input  wire                      carry,
	input  wire cpuIsaPkg::flagTestT flagTest,
	output logic                     branchTaken
);
	logic zeroQ, negQ, carryQ; // from last alu-type instruction

	always_ff @(posedge CLK or negedge arstN) begin
		if (!arstN) begin
			zeroQ  <= 1'b0;
			negQ   <= 1'b0;
			carryQ <= 1'b0;
		end else if (flagLoad) begin
			zeroQ  <= zero;
			negQ   <= negative;
			carryQ <= carry;
		end
	end

	always_comb begin
		case (flagTest)
			cpuIsaPkg::testZero:    branchTaken = zeroQ;
			cpuIsaPkg::testNonZero: branchTaken = ~zeroQ;
			cpuIsaPkg::testAlways:  branchTaken = 1'b1;
			cpuIsaPkg::testNeg:     branchTaken = negQ;
			cpuIsaPkg::testNonNeg:  branchTaken = ~negQ;
			cpuIsaPkg::testCarry:   branchTaken = carryQ;
			cpuIsaPkg::testNoCarry: branchTaken = ~carryQ;
			default:                branchTaken = 1'b0; // never
		endcase
	end

endmodule

`default_nettype wire

/* datapath/regFile.sv */
`timescale 1ns/1ps
`default_nettype none
`include "cpu_macros.svh"

module regFile (
	input  wire                     CLK,
	input  wire                     arstN,
	input  wire                     we,
	input  wire cpuIsaPkg::regAddrT rdAddr,
	input  wire cpuIsaPkg::regAddrT rsAddr,
	input  wire cpuIsaPkg::regAddrT rtAddr,
	input  wire cpuIsaPkg::wordT    wrData,
	output cpuIsaPkg::wordT         rsData,
	output cpuIsaPkg::wordT         rtData
);
	cpuIsaPkg::wordT regs [`CPU_REG_COUNT];

	always_ff @(posedge CLK or negedge arstN) begin
		if (!arstN) begin
			for (int i = 0; i < `CPU_REG_COUNT; i++) begin
				regs[i] <= '0;
			end
		end else if (we) begin
			regs[rdAddr] <= wrData;
		end
	end

	assign rsData = regs[rsAddr];
	assign rtData = regs[rtAddr];

endmodule

`default_nettype wire

/* design/cpuTop.sv */
`timescale 1ns/1ps
`default_nettype none
`include "cpu_macros.svh"

module cpuTop (
	input  wire                      CLK,
	input  wire                      arstN,
	input  wire                      run,
	input  wire                      loadWe,
	input  wire cpuIsaPkg::imemAddrT loadAddr,
	input  wire cpuIsaPkg::instrT    loadData,
	output logic                     storeValid,
	output cpuIsaPkg::dmemAddrT      storeAddr,
	output cpuIsaPkg::wordT          storeData,
	output logic                     halted
);
	cpuIsaPkg::aluOpT    aluOp;
	cpuIsaPkg::flagTestT flagTest;
	cpuCtrlPkg::bSelT    bSel;
	cpuCtrlPkg::wbSelT   wbSel;
	logic signExt, dmWe, rfWe, irWe, pcWe, pcBranchSel, idle;

	cpuIsaPkg::imemAddrT pc, seqPc;
	cpuIsaPkg::instrT    instr, imemRdData;
	cpuIsaPkg::regAddrT  rtAddr;
	cpuIsaPkg::immT      imm;
	cpuIsaPkg::wordT     rsData, rtData, immExt, aluB, aluResult, memSum, dmemRdData, wbData;
	cpuIsaPkg::dmemAddrT dmemAddr;
	logic aluZero, aluNeg, aluCarry, flagLoad, branchTaken;

	controlUnit control_i (
		.CLK(CLK), .arstN(arstN), .run(run),
		.instrType(cpuIsaPkg::typeOf(instr)), .op(cpuIsaPkg::opOf(instr)),
		.aluOp(aluOp), .flagTest(flagTest), .signExt(signExt), .bSel(bSel),
		.dmWe(dmWe), .rfWe(rfWe), .wbSel(wbSel), .irWe(irWe), .pcWe(pcWe),
		.pcBranchSel(pcBranchSel), .halted(halted), .idle(idle)
	);

	// ####################
	// fetch

	wordMemory #(.WIDTH($bits(cpuIsaPkg::instrT)), .DEPTH(`CPU_IMEM_DEPTH)) imem_i (
		.CLK(CLK), .we(loadWe && idle), // load port only while stopped
		.wrAddr(loadAddr), .rdAddr(pc), .wrData(loadData), .rdData(imemRdData)
	);

	fetchUnit fetch_i (
		.CLK(CLK), .arstN(arstN), .irWe(irWe), .pcWe(pcWe), .pcBranchSel(pcBranchSel),
		.branchTaken(branchTaken), .target(cpuIsaPkg::imemAddrT'(aluResult)),
		.instrIn(imemRdData), .pc(pc), .instr(instr)
	);

	// ####################
	// operands

	// stores read rd on the second port since imm covers rt
	assign rtAddr = (cpuIsaPkg::typeOf(instr) == cpuIsaPkg::typeMem) ?
		cpuIsaPkg::rdOf(instr) : cpuIsaPkg::rtOf(instr);
	assign imm    = cpuIsaPkg::immOf(instr);
	assign immExt = signExt ? cpuIsaPkg::wordT'($signed(imm)) : {8'b0, imm[7:0]}; // targets: low byte
	assign aluB   = (bSel == cpuCtrlPkg::bSelImm) ? immExt : rtData;

	regFile regs_i (
		.CLK(CLK), .arstN(arstN), .we(rfWe), .rdAddr(cpuIsaPkg::rdOf(instr)),
		.rsAddr(cpuIsaPkg::rsOf(instr)), .rtAddr(rtAddr), .wrData(wbData),
		.rsData(rsData), .rtData(rtData)
	);

	alu alu_i (
		.CLK(CLK), .arstN(arstN), .aluOp(aluOp), .a(rsData), .b(aluB),
		.result(aluResult), .zero(aluZero), .negative(aluNeg), .carry(aluCarry)
	);

	assign flagLoad = rfWe && (wbSel == cpuCtrlPkg::wbAlu); // alu-type writeback

	flagUnit flags_i (
		.CLK(CLK), .arstN(arstN), .flagLoad(flagLoad), .zero(aluZero),
		.negative(aluNeg), .carry(aluCarry), .flagTest(flagTest), .branchTaken(branchTaken)
	);

	// ####################
	// data memory and writeback

	assign memSum   = rsData + immExt; // needed in execute, before the alu register
	assign dmemAddr = cpuIsaPkg::dmemAddrT'(memSum);

	wordMemory #(.WIDTH($bits(cpuIsaPkg::wordT)), .DEPTH(`CPU_DMEM_DEPTH)) dmem_i (
		.CLK(CLK), .we(dmWe), .wrAddr(dmemAddr), .rdAddr(dmemAddr),
		.wrData(rtData), .rdData(dmemRdData)
	);

	assign storeValid = dmWe;
	assign storeAddr  = dmemAddr;
	assign storeData  = rtData;

	assign seqPc = pc + 1'b1; // link value

	always_comb begin
		case (wbSel)
			cpuCtrlPkg::wbAlu: wbData = aluResult;
			cpuCtrlPkg::wbMem: wbData = dmemRdData;
			default:           wbData = cpuIsaPkg::wordT'(seqPc);
		endcase
	end

endmodule

`default_nettype wire

/* design/fetchUnit.sv */
`timescale 1ns/1ps
`default_nettype none

module fetchUnit (
	input  wire                      CLK,
	input  wire                      arstN,
	input  wire                      irWe,
	input  wire                      pcWe,
	input  wire                      pcBranchSel,
	input  wire                      branchTaken,
	input  wire cpuIsaPkg::imemAddrT target,
	input  wire cpuIsaPkg::instrT    instrIn,
	output cpuIsaPkg::imemAddrT      pc,
	output cpuIsaPkg::instrT         instr
);
	cpuIsaPkg::imemAddrT nextPc;

	// jumps arrive with an always-true test
	assign nextPc = (pcBranchSel && branchTaken) ? target : pc + 1'b1;

	always_ff @(posedge CLK or negedge arstN) begin
		if (!arstN) begin
			pc    <= '0;
			instr <= '0;
		end else begin
			if (irWe) begin
				instr <= instrIn;
			end
			if (pcWe) begin
				pc <= nextPc;
			end
		end
	end

endmodule

`default_nettype wire

/* design/wordMemory.sv */
`timescale 1ns/1ps
`default_nettype none

module wordMemory #(
	parameter int WIDTH = 16,
	parameter int DEPTH = 256
) (
	input  wire                       CLK,
	input  wire                       we,
	input  wire [$clog2(DEPTH)-1:0]   wrAddr,
	input  wire [$clog2(DEPTH)-1:0]   rdAddr,
	input  wire [WIDTH-1:0]           wrData,
	output logic [WIDTH-1:0]          rdData
);
	logic [WIDTH-1:0] mem [DEPTH];

	always_ff @(posedge CLK) begin
		if (we) begin
			mem[wrAddr] <= wrData;
		end
	end

	assign rdData = mem[rdAddr]; // async read

endmodule

`default_nettype wire

/* files.f */
+incdir+common
common/cpuIsaPkg.sv
common/cpuCtrlPkg.sv
design/wordMemory.sv
design/fetchUnit.sv
control/controlUnit.sv
datapath/regFile.sv
datapath/alu.sv
datapath/flagUnit.sv
design/cpuTop.sv
tests/cpuTb.sv

/* tests/cpuTb.sv */
`timescale 1ns/1ps
`default_nettype none
`include "cpu_macros.svh"

module cpuTb;

	logic                CLK;
	logic                arstN;
	logic                run;
	logic                loadWe;
	cpuIsaPkg::imemAddrT loadAddr;
	cpuIsaPkg::instrT    loadData;
	logic                storeValid;
	cpuIsaPkg::dmemAddrT storeAddr;
	cpuIsaPkg::wordT     storeData;
	logic                halted;

	localparam cpuIsaPkg::aluOpT opLoad  = 5'b00000;
	localparam cpuIsaPkg::aluOpT opStore = 5'b10000; // op[4] selects store

	cpuIsaPkg::instrT    prog [$];
	cpuIsaPkg::dmemAddrT expAddr [$];
	cpuIsaPkg::wordT     expData [$];
	string  testName;
	integer seed = 32'h4fe1;
	int     storeIdx = 0;
	int     runCycles = 0;
	int     cycleLimit = 0;
	logic   running = 1'b0;

	cpuTop cpuTop_i (
		.CLK(CLK), .arstN(arstN), .run(run), .loadWe(loadWe), .loadAddr(loadAddr),
		.loadData(loadData), .storeValid(storeValid), .storeAddr(storeAddr),
		.storeData(storeData), .halted(halted)
	);

	always #2 CLK = ~CLK; // 4 ns period

	// ####################
	// reference model

	function automatic cpuIsaPkg::instrT encodeInstr(input logic [2:0] typ,
			input cpuIsaPkg::aluOpT op, input cpuIsaPkg::regAddrT rd,
			input cpuIsaPkg::regAddrT rs, input logic [15:0] imm);
		return {typ, op, rd, rs, 2'b00, imm}; // rt sits in imm[2:0]
	endfunction

	function automatic cpuIsaPkg::wordT aluModel(input cpuIsaPkg::aluOpT op,
			input cpuIsaPkg::wordT a, input cpuIsaPkg::wordT b, output logic carry);
		logic [16:0]     wide;
		cpuIsaPkg::wordT res;
		carry = 1'b0;
		case (op)
			cpuIsaPkg::aluAdd: begin
				wide  = {1'b0, a} + {1'b0, b};
				res   = wide[15:0];
				carry = wide[16];
			end
			cpuIsaPkg::aluSub: begin
				res   = a - b;
				carry = (a < b); // borrow
			end
			cpuIsaPkg::aluAnd:   res = a & b;
			cpuIsaPkg::aluOr:    res = a | b;
			cpuIsaPkg::aluXor:   res = a ^ b;
			cpuIsaPkg::aluShl:   res = a << b[3:0];
			cpuIsaPkg::aluShr:   res = a >> b[3:0];
			cpuIsaPkg::aluPassB: res = b;
			default:             res = '0;
		endcase
		return res;
	endfunction

	function automatic logic condModel(input cpuIsaPkg::flagTestT test, input logic z,
			input logic n, input logic c);
		case (test)
			3'b001:  return z;
			3'b010:  return !z;
			3'b011:  return 1'b1;
			3'b100:  return n;
			3'b101:  return !n;
			3'b110:  return c;
			3'b111:  return !c;
			default: return 1'b0; // never
		endcase
	endfunction

	// fills expAddr and expData and returns the instruction count
	function automatic int runInstrSetModel();
		cpuIsaPkg::wordT     regs [`CPU_REG_COUNT];
		cpuIsaPkg::wordT     mem [`CPU_DMEM_DEPTH];
		cpuIsaPkg::wordT     r;
		cpuIsaPkg::wordT     addr;
		cpuIsaPkg::instrT    ins;
		cpuIsaPkg::imemAddrT pc;
		logic zf, nf, cf, c, done;
		int count;
		foreach (regs[i]) begin
			regs[i] = '0;
		end
		pc    = '0;
		zf    = 1'b0;
		nf    = 1'b0;
		cf    = 1'b0;
		done  = 1'b0;
		count = 0;
		expAddr.delete();
		expData.delete();
		while (!done && count < 1000) begin
			if (int'(pc) >= prog.size()) begin
				done = 1'b1;
			end else begin
				ins   = prog[pc];
				count = count + 1;
				pc    = pc + 1'b1; // also the link value
				case (ins[31:29])
					cpuIsaPkg::typeAluReg, cpuIsaPkg::typeAluImm: begin
						r = aluModel(ins[28:24], regs[ins[20:18]],
							(ins[31:29] == cpuIsaPkg::typeAluImm) ? ins[15:0] : regs[ins[2:0]], c);
						regs[ins[23:21]] = r;
						zf = (r == '0);
						nf = r[15];
						cf = c;
					end
					cpuIsaPkg::typeMem: begin
						addr = regs[ins[20:18]] + ins[15:0];
						if (ins[28]) begin
							expAddr.push_back(addr[7:0]);
							expData.push_back(regs[ins[23:21]]);
							mem[addr[7:0]] = regs[ins[23:21]];
						end else begin
							regs[ins[23:21]] = mem[addr[7:0]];
						end
					end
					cpuIsaPkg::typeBranch: begin
						if (condModel(ins[28:26], zf, nf, cf)) begin
							pc = ins[7:0];
						end
					end
					cpuIsaPkg::typeJump: begin
						regs[ins[23:21]] = {8'h00, pc};
						pc = ins[7:0];
					end
					cpuIsaPkg::typeHalt: done = 1'b1;
					default: ;
				endcase
			end
		end
		return count;
	endfunction

	// ####################
	// checks

	task automatic stopOnFailure();
		$display("** FAIL **");
		$fatal(1, "simulation stopped at the first failure");
	endtask

	task automatic checkStore(input int idx, input cpuIsaPkg::dmemAddrT expA,
			input cpuIsaPkg::wordT expD, input cpuIsaPkg::dmemAddrT actA,
			input cpuIsaPkg::wordT actD);
		if (expA !== actA || expD !== actD) begin
			$display("Error %s: store %0d expected addr %h data %h, actual addr %h data %h",
				testName, idx, expA, expD, actA, actD);
			stopOnFailure();
		end
	endtask

	task automatic checkHalted(input logic act, input int expCount, input int actCount);
		if (act !== 1'b1) begin
			$display("%s: halted dropped after the program stopped", testName);
			stopOnFailure();
		end else if (expCount != actCount) begin
			$display("Error %s: store count expected %0d, actual %0d",
				testName, expCount, actCount);
			stopOnFailure();
		end
	endtask

	always @(negedge CLK) begin // mid-cycle where outputs are settled
		if (arstN && storeValid) begin
			if (storeIdx >= expAddr.size()) begin
				$display("%s: store of %h to address %h went past the expected list",
					testName, storeData, storeAddr);
				stopOnFailure();
			end else begin
				checkStore(storeIdx, expAddr[storeIdx], expData[storeIdx], storeAddr, storeData);
				storeIdx = storeIdx + 1;
			end
		end
	end

	always @(posedge CLK) begin
		if (running) begin
			runCycles = runCycles + 1;
			if (runCycles > cycleLimit) begin
				$display("%s: halted did not rise within the limit of %0d run cycles",
					testName, cycleLimit);
				stopOnFailure();
			end
		end
	end

	// ####################
	// stimulus

	task automatic stepCycle();
		@(posedge CLK);
		#0.5;
	endtask

	task automatic appendInstr(input logic [2:0] typ, input cpuIsaPkg::aluOpT op,
			input cpuIsaPkg::regAddrT rd, input cpuIsaPkg::regAddrT rs, input logic [15:0] imm);
		prog.push_back(encodeInstr(typ, op, rd, rs, imm));
	endtask

	task automatic applyReset();
		arstN  = 1'b0;
		run    = 1'b0;
		loadWe = 1'b0;
		repeat (4) stepCycle();
		arstN = 1'b1;
	endtask

	task automatic loadProgram();
		for (int i = 0; i < prog.size(); i++) begin
			loadWe   = 1'b1;
			loadAddr = cpuIsaPkg::imemAddrT'(i);
			loadData = prog[i];
			stepCycle();
		end
		loadWe = 1'b0;
	endtask

	task automatic runTest(input string name, input logic pokeLoad,
			input cpuIsaPkg::imemAddrT pokeAddr, input cpuIsaPkg::instrT pokeData);
		int count;
		testName   = name;
		count      = runInstrSetModel();
		cycleLimit = cycleLimit + 4 * count + `CPU_HALT_MARGIN;
		applyReset();
		loadProgram();
		storeIdx = 0;
		run = 1'b1;
		stepCycle();
		run     = 1'b0;
		running = 1'b1;
		while (!halted) begin
			loadWe   = pokeLoad; // core busy so these writes are dropped
			loadAddr = pokeAddr;
			loadData = pokeData;
			stepCycle();
		end
		running = 1'b0;
		loadWe  = 1'b0;
		repeat (8) stepCycle();
		checkHalted(halted, expAddr.size(), storeIdx);
	endtask

	initial begin
		cpuIsaPkg::aluOpT opList [9];
		cpuIsaPkg::wordT  immList [5];
		int base;
		CLK      = 1'b0;
		arstN    = 1'b0;
		run      = 1'b0;
		loadWe   = 1'b0;
		loadAddr = '0;
		loadData = '0;
		opList = '{cpuIsaPkg::aluAdd, cpuIsaPkg::aluSub, cpuIsaPkg::aluAnd, cpuIsaPkg::aluOr,
			cpuIsaPkg::aluXor, cpuIsaPkg::aluShl, cpuIsaPkg::aluShr, cpuIsaPkg::aluPassB,
			5'b11111};

		// register-register alu
		prog.delete();
		appendInstr(cpuIsaPkg::typeAluImm, cpuIsaPkg::aluAdd, 3'd1, 3'd0, 16'($random(seed)));
		appendInstr(cpuIsaPkg::typeAluImm, cpuIsaPkg::aluAdd, 3'd2, 3'd0, 16'($random(seed)));
		foreach (opList[i]) begin
			appendInstr(cpuIsaPkg::typeAluReg, opList[i], 3'd3, 3'd1, 16'd2); // r3 = r1 op r2
			appendInstr(cpuIsaPkg::typeMem, opStore, 3'd3, 3'd0, 16'(i));
		end
		appendInstr(cpuIsaPkg::typeHalt, 5'd0, 3'd0, 3'd0, 16'd0);
		runTest("aluReg", 1'b0, '0, '0);

		// immediate alu and sign extension
		prog.delete();
		immList = '{16'hffff, 16'h8000, 16'h7fff, 16'h0005, 16'($random(seed))};
		appendInstr(cpuIsaPkg::typeAluImm, cpuIsaPkg::aluAdd, 3'd1, 3'd0, 16'($random(seed)));
		foreach (immList[i]) begin
			appendInstr(cpuIsaPkg::typeAluImm, cpuIsaPkg::aluAdd, 3'd2, 3'd1, immList[i]);
			appendInstr(cpuIsaPkg::typeMem, opStore, 3'd2, 3'd0, 16'(32 + i));
		end
		appendInstr(cpuIsaPkg::typeAluImm, cpuIsaPkg::aluSub, 3'd2, 3'd1, 16'hfff0);
		appendInstr(cpuIsaPkg::typeMem, opStore, 3'd2, 3'd0, 16'h0028);
		appendInstr(cpuIsaPkg::typeAluImm, cpuIsaPkg::aluXor, 3'd2, 3'd1, 16'h8001);
		appendInstr(cpuIsaPkg::typeMem, opStore, 3'd2, 3'd0, 16'h0029);
		appendInstr(cpuIsaPkg::typeAluImm, cpuIsaPkg::aluAdd, 3'd4, 3'd0, 16'h0030);
		appendInstr(cpuIsaPkg::typeMem, opStore, 3'd1, 3'd4, 16'hfffe); // negative offset
		appendInstr(cpuIsaPkg::typeHalt, 5'd0, 3'd0, 3'd0, 16'd0);
		runTest("aluImm", 1'b0, '0, '0);

		// store, load back, store again
		prog.delete();
		appendInstr(cpuIsaPkg::typeAluImm, cpuIsaPkg::aluAdd, 3'd1, 3'd0, 16'($random(seed)));
		appendInstr(cpuIsaPkg::typeMem, opStore, 3'd1, 3'd0, 16'h0040);
		appendInstr(cpuIsaPkg::typeMem, opLoad, 3'd5, 3'd0, 16'h0040);
		appendInstr(cpuIsaPkg::typeMem, opStore, 3'd5, 3'd0, 16'h0041);
		appendInstr(cpuIsaPkg::typeAluImm, cpuIsaPkg::aluAdd, 3'd6, 3'd0, 16'h0052);
		appendInstr(cpuIsaPkg::typeMem, opLoad, 3'd7, 3'd6, 16'hffee); // back to 0x40
		appendInstr(cpuIsaPkg::typeMem, opStore, 3'd7, 3'd0, 16'h0042);
		appendInstr(cpuIsaPkg::typeAluImm, cpuIsaPkg::aluAdd, 3'd2, 3'd0, 16'($random(seed)));
		appendInstr(cpuIsaPkg::typeMem, opStore, 3'd2, 3'd6, 16'h0000);
		appendInstr(cpuIsaPkg::typeMem, opLoad, 3'd3, 3'd6, 16'h0000);
		appendInstr(cpuIsaPkg::typeMem, opStore, 3'd3, 3'd0, 16'h0043);
		appendInstr(cpuIsaPkg::typeHalt, 5'd0, 3'd0, 3'd0, 16'd0);
		runTest("loadStore", 1'b0, '0, '0);

		// every flag test after four flag patterns
		prog.delete();
		appendInstr(cpuIsaPkg::typeAluImm, cpuIsaPkg::aluAdd, 3'd1, 3'd0, 16'h0001);
		appendInstr(cpuIsaPkg::typeAluImm, cpuIsaPkg::aluAdd, 3'd2, 3'd0, 16'h0002);
		appendInstr(cpuIsaPkg::typeAluImm, cpuIsaPkg::aluAdd, 3'd6, 3'd0, 16'hffff);
		appendInstr(cpuIsaPkg::typeAluImm, cpuIsaPkg::aluAdd, 3'd4, 3'd0, 16'h00aa);
		appendInstr(cpuIsaPkg::typeAluImm, cpuIsaPkg::aluAdd, 3'd5, 3'd0, 16'h00bb);
		for (int s = 0; s < 4; s++) begin
			for (int t = 0; t < 8; t++) begin
				base = prog.size();
				case (s)
					0: appendInstr(cpuIsaPkg::typeAluReg, cpuIsaPkg::aluSub, 3'd3, 3'd1, 16'd1);
					1: appendInstr(cpuIsaPkg::typeAluReg, cpuIsaPkg::aluSub, 3'd3, 3'd1, 16'd2);
					2: appendInstr(cpuIsaPkg::typeAluReg, cpuIsaPkg::aluAdd, 3'd3, 3'd6, 16'd1);
					default: appendInstr(cpuIsaPkg::typeAluReg, cpuIsaPkg::aluAdd, 3'd3, 3'd1, 16'd1);
				endcase
				appendInstr(cpuIsaPkg::typeBranch, {3'(t), 2'b00}, 3'd0, 3'd0, 16'(base + 4));
				appendInstr(cpuIsaPkg::typeMem, opStore, 3'd4, 3'd0, 16'(128 + s * 8 + t));
				appendInstr(cpuIsaPkg::typeBranch, {cpuIsaPkg::testAlways, 2'b00}, 3'd0, 3'd0,
					16'(base + 5));
				appendInstr(cpuIsaPkg::typeMem, opStore, 3'd5, 3'd0, 16'(128 + s * 8 + t));
			end
		end
		appendInstr(cpuIsaPkg::typeHalt, 5'd0, 3'd0, 3'd0, 16'd0);
		runTest("branch", 1'b0, '0, '0);

		// jump with link
		prog.delete();
		appendInstr(cpuIsaPkg::typeAluImm, cpuIsaPkg::aluAdd, 3'd1, 3'd0, 16'h1234);
		appendInstr(cpuIsaPkg::typeJump, 5'd0, 3'd7, 3'd0, 16'd4);
		appendInstr(cpuIsaPkg::typeMem, opStore, 3'd1, 3'd0, 16'h0060); // skipped
		appendInstr(cpuIsaPkg::typeHalt, 5'd0, 3'd0, 3'd0, 16'd0);
		appendInstr(cpuIsaPkg::typeMem, opStore, 3'd7, 3'd0, 16'h0061);
		appendInstr(cpuIsaPkg::typeJump, 5'd0, 3'd6, 3'd0, 16'd8);
		appendInstr(cpuIsaPkg::typeMem, opStore, 3'd1, 3'd0, 16'h0062); // skipped
		appendInstr(cpuIsaPkg::typeHalt, 5'd0, 3'd0, 3'd0, 16'd0);
		appendInstr(cpuIsaPkg::typeMem, opStore, 3'd6, 3'd0, 16'h0063);
		appendInstr(cpuIsaPkg::typeHalt, 5'd0, 3'd0, 3'd0, 16'd0);
		runTest("jumpLink", 1'b0, '0, '0);

		// halt with load port writes aimed at it while running
		prog.delete();
		appendInstr(cpuIsaPkg::typeAluImm, cpuIsaPkg::aluAdd, 3'd1, 3'd0, 16'($random(seed)));
		appendInstr(cpuIsaPkg::typeMem, opStore, 3'd1, 3'd0, 16'h0070);
		appendInstr(cpuIsaPkg::typeHalt, 5'd0, 3'd0, 3'd0, 16'd0);
		appendInstr(cpuIsaPkg::typeMem, opStore, 3'd1, 3'd0, 16'h0071);
		appendInstr(cpuIsaPkg::typeMem, opStore, 3'd1, 3'd0, 16'h0072);
		runTest("halt", 1'b1, 8'd2,
			encodeInstr(cpuIsaPkg::typeMem, opStore, 3'd1, 3'd0, 16'h007f));

		$display("** PASS **");
		$finish;
	end

endmodule

`default_nettype wire
